// ==== verilog/fir_pkg.sv ====
`default_nettype none

package fir_pkg;

	// filter sizes
	localparam int DATA_W       = 16;
	localparam int COEF_W       = 16;
	localparam int NUM_SEG      = 2;
	localparam int TAPS_PER_SEG = 4;
	localparam int TOTAL_TAPS   = NUM_SEG * TAPS_PER_SEG;
	localparam int TAP_IDX_W    = $clog2(TAPS_PER_SEG);
	localparam int PROD_W       = DATA_W + COEF_W;
	localparam int PART_W       = PROD_W + $clog2(TAPS_PER_SEG);
	localparam int TREE_LEVELS  = $clog2(NUM_SEG);
	localparam int SUM_W        = PART_W + TREE_LEVELS;

	// edge register, shift, MAC, partial register, tree levels, output register
	localparam int FIR_LATENCY = TAPS_PER_SEG + TREE_LEVELS + 3;

	// bus sizes and address map
	localparam int ADDR_W = 12;
	localparam int APB_DW = 32;

	localparam logic [3:0] TGT_REGS = 4'd0;
	localparam logic [3:0] TGT_SEG0 = 4'd1;

	localparam logic [7:0] REG_CTRL      = 8'h00;
	localparam logic [7:0] REG_SAMPLE    = 8'h01;
	localparam logic [7:0] REG_Y_LO      = 8'h02;
	localparam logic [7:0] REG_Y_HI      = 8'h03;
	localparam logic [7:0] REG_SHIFT_OUT = 8'h04;
	localparam logic [7:0] REG_OVERRUN   = 8'h05;

	typedef struct packed {
		logic [3:0] target;
		logic [7:0] offset;
	} reg_addr_t;

	typedef struct packed {
		logic [3:0] target;
		logic [7:0] coef_idx;
	} coef_addr_t;

	// one word address, seen as register or coefficient slot
	typedef union packed {
		reg_addr_t  regs;
		coef_addr_t coef;
	} apb_addr_u;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	typedef logic [NUM_SEG-1:0][PART_W-1:0] seg_part_t;

	typedef struct packed {
		logic              valid;
		logic [SUM_W-1:0]  y;
		logic [DATA_W-1:0] shift_out;
	} fir_out_t;

	typedef struct packed {
		logic [1:0] quarter;
		logic [3:0] idx;
	} tone_phase_t;

	// first quarter of a full-scale sine, 64 steps per period
	localparam logic signed [DATA_W-1:0] TONE_TABLE [16] = '{
		16'sd0,     16'sd3212,  16'sd6393,  16'sd9512,
		16'sd12539, 16'sd15446, 16'sd18204, 16'sd20787,
		16'sd23170, 16'sd25329, 16'sd27245, 16'sd28898,
		16'sd30273, 16'sd31356, 16'sd32137, 16'sd32609
	};

endpackage

`default_nettype wire

// ==== verilog/apb_splitter.sv ====
`timescale 1ns/10ps
`default_nettype none

module apb_splitter import fir_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  apb_req_t apb_i,
	output apb_rsp_t apb_o,
	output apb_req_t regs_req_o,
	input  apb_rsp_t regs_rsp_i,
	output apb_req_t seg_req_o [NUM_SEG],
	input  apb_rsp_t seg_rsp_i [NUM_SEG]
);

	apb_addr_u          addr;
	logic               regs_hit;
	logic [NUM_SEG-1:0] seg_hit;

	assign addr     = apb_i.paddr;
	assign regs_hit = addr.regs.target == TGT_REGS;

	always_comb begin
		regs_req_o      = apb_i;
		regs_req_o.psel = apb_i.psel & regs_hit;
	end

	for (genvar k = 0; k < NUM_SEG; k++) begin : g_seg
		// segment k sits at target k+1
		assign seg_hit[k] = addr.regs.target == TGT_SEG0 + 4'(k);

		always_comb begin
			seg_req_o[k]      = apb_i;
			seg_req_o[k].psel = apb_i.psel & seg_hit[k];
		end
	end

	always_comb begin
		apb_o = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};
		if (regs_hit) begin
			apb_o = regs_rsp_i;
		end else if (seg_hit == '0) begin
			// nobody behind this target
			apb_o.pslverr = apb_i.psel & apb_i.penable;
		end
		for (int k = 0; k < NUM_SEG; k++) begin
			if (seg_hit[k]) begin
				apb_o = seg_rsp_i[k];
			end
		end
	end

	// access phase only ever follows a setup phase
	a_setup_before_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(apb_i.penable) |-> $past(apb_i.psel));

endmodule

`default_nettype wire

// ==== verilog/fir_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module fir_regs import fir_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  apb_req_t          req_i,
	output apb_rsp_t          rsp_o,
	output logic              tone_en_o,
	output logic              inject_valid_o,
	output logic [DATA_W-1:0] inject_data_o,
	input  logic              accept_i,
	input  logic              overrun_i,
	input  fir_out_t          result_i
);

	apb_addr_u         addr;
	logic              access;
	logic              wr_en;
	logic              mapped;
	logic [APB_DW-1:0] rdata;
	logic              tone_en_q;
	logic              pending_q;
	logic [DATA_W-1:0] inject_q;
	logic [DATA_W-1:0] shift_out_q;
	logic [SUM_W-1:0]  y_q;
	logic [15:0]       overrun_q;

	assign addr   = req_i.paddr;
	assign access = req_i.psel & req_i.penable;
	assign wr_en  = access & req_i.pwrite;

	always_comb begin
		mapped = 1'b1;
		rdata  = '0;
		case (addr.regs.offset)
			REG_CTRL:      rdata = {31'b0, tone_en_q};
			REG_SAMPLE:    rdata = '0;
			REG_Y_LO:      rdata = y_q[31:0];
			REG_Y_HI:      rdata = {{(64 - SUM_W){y_q[SUM_W-1]}}, y_q[SUM_W-1:32]};
			REG_SHIFT_OUT: rdata = {{(APB_DW - DATA_W){shift_out_q[DATA_W-1]}}, shift_out_q};
			REG_OVERRUN:   rdata = {16'b0, overrun_q};
			default:       mapped = 1'b0;
		endcase
	end

	assign rsp_o.prdata  = (req_i.psel & ~req_i.pwrite) ? rdata : '0;
	assign rsp_o.pready  = 1'b1;
	assign rsp_o.pslverr = access & ~mapped;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			tone_en_q <= 1'b0;
			pending_q <= 1'b0;
			inject_q  <= '0;
		end else begin
			if (wr_en && addr.regs.offset == REG_CTRL) begin
				tone_en_q <= req_i.pwdata[0];
			end
			// new write is meant for the next accept
			if (wr_en && addr.regs.offset == REG_SAMPLE) begin
				pending_q <= 1'b1;
				inject_q  <= req_i.pwdata[DATA_W-1:0];
			end else if (accept_i) begin
				pending_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			y_q         <= '0;
			shift_out_q <= '0;
			overrun_q   <= '0;
		end else begin
			if (result_i.valid) begin
				y_q         <= result_i.y;
				shift_out_q <= result_i.shift_out;
			end
			// saturating count
			if (overrun_i && overrun_q != '1) begin
				overrun_q <= overrun_q + 1'b1;
			end
		end
	end

	assign tone_en_o      = tone_en_q;
	assign inject_valid_o = pending_q;
	assign inject_data_o  = inject_q;

	a_inject_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
		inject_valid_o && !accept_i |=> inject_valid_o);

endmodule

`default_nettype wire

// ==== verilog/fir_segment.sv ====
`timescale 1ns/10ps
`default_nettype none

module fir_segment import fir_pkg::*; (
	input  logic                     clk_i,
	input  logic                     rst_ni,
	input  apb_req_t                 req_i,
	output apb_rsp_t                 rsp_o,
	input  logic                     start_i,
	input  logic        [DATA_W-1:0] sample_i,
	output logic        [DATA_W-1:0] shift_o,
	output logic signed [PART_W-1:0] part_o,
	output logic                     part_valid_o
);

	apb_addr_u                addr;
	logic                     access;
	logic                     idx_ok;
	logic [TAP_IDX_W-1:0]     coef_sel;
	logic signed [DATA_W-1:0] taps_q [TAPS_PER_SEG];
	logic signed [COEF_W-1:0] coef_q [TAPS_PER_SEG];
	logic                     running_q;
	logic                     done_q;
	logic [TAP_IDX_W-1:0]     idx_q;
	logic signed [PROD_W-1:0] prod;
	logic signed [PART_W-1:0] prod_ext;
	logic signed [PART_W-1:0] acc_q;

	assign addr     = req_i.paddr;
	assign access   = req_i.psel & req_i.penable;
	assign idx_ok   = addr.coef.coef_idx < 8'(TAPS_PER_SEG);
	assign coef_sel = addr.coef.coef_idx[TAP_IDX_W-1:0];

	// coefficients read back sign extended
	assign rsp_o.prdata  = (req_i.psel & ~req_i.pwrite & idx_ok) ? 32'(coef_q[coef_sel]) : '0;
	assign rsp_o.pready  = 1'b1;
	assign rsp_o.pslverr = access & ~idx_ok;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 0; i < TAPS_PER_SEG; i++) begin
				coef_q[i] <= '0;
			end
		end else if (access && req_i.pwrite && idx_ok) begin
			coef_q[coef_sel] <= req_i.pwdata[COEF_W-1:0];
		end
	end

	// delay slice, tap 0 is the newest sample
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 0; i < TAPS_PER_SEG; i++) begin
				taps_q[i] <= '0;
			end
		end else if (start_i) begin
			taps_q[0] <= sample_i;
			for (int i = 1; i < TAPS_PER_SEG; i++) begin
				taps_q[i] <= taps_q[i-1];
			end
		end
	end

	assign shift_o = taps_q[TAPS_PER_SEG-1];

	// one shared multiplier walks the taps
	assign prod     = taps_q[idx_q] * coef_q[idx_q];
	assign prod_ext = prod;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			running_q <= 1'b0;
			done_q    <= 1'b0;
			idx_q     <= '0;
			acc_q     <= '0;
		end else begin
			done_q <= 1'b0;
			if (start_i) begin
				running_q <= 1'b1;
				idx_q     <= '0;
				acc_q     <= '0;
			end else if (running_q) begin
				acc_q <= acc_q + prod_ext;
				idx_q <= idx_q + 1'b1;
				if (idx_q == TAP_IDX_W'(TAPS_PER_SEG - 1)) begin
					running_q <= 1'b0;
					done_q    <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			part_o       <= '0;
			part_valid_o <= 1'b0;
		end else begin
			part_valid_o <= done_q;
			if (done_q) begin
				part_o <= acc_q;
			end
		end
	end

	// one sample in flight, the top must hold off new samples
	a_no_start_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
		start_i |-> !running_q);

endmodule

`default_nettype wire

// ==== verilog/adder_tree.sv ====
`timescale 1ns/10ps
`default_nettype none

module adder_tree import fir_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    valid_i,
	input  seg_part_t               parts_i,
	output logic                    valid_o,
	output logic signed [SUM_W-1:0] sum_o
);

	logic signed [SUM_W-1:0] leaf [NUM_SEG];
	logic signed [SUM_W-1:0] node_q [NUM_SEG-1];
	logic [TREE_LEVELS-1:0]  valid_q;

	// widen every partial to the full sum width up front
	for (genvar n = 0; n < NUM_SEG; n++) begin : g_leaf
		assign leaf[n] = $signed(parts_i[n]);
	end

	// heap order, node i sums children 2i+1 and 2i+2
	for (genvar i = 0; i < NUM_SEG - 1; i++) begin : g_node
		logic signed [SUM_W-1:0] lhs;
		logic signed [SUM_W-1:0] rhs;

		if (2 * i + 1 >= NUM_SEG - 1) begin : g_from_leaf
			assign lhs = leaf[2 * i + 1 - (NUM_SEG - 1)];
			assign rhs = leaf[2 * i + 2 - (NUM_SEG - 1)];
		end else begin : g_from_node
			assign lhs = node_q[2 * i + 1];
			assign rhs = node_q[2 * i + 2];
		end

		always_ff @(posedge clk_i, negedge rst_ni) begin
			if (!rst_ni) begin
				node_q[i] <= '0;
			end else begin
				node_q[i] <= lhs + rhs;
			end
		end
	end

	// valid follows the data one level per cycle
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= '0;
		end else begin
			valid_q <= (valid_q << 1) | TREE_LEVELS'(valid_i);
		end
	end

	assign valid_o = valid_q[TREE_LEVELS-1];
	assign sum_o   = node_q[0];

endmodule

`default_nettype wire

// ==== verilog/tone_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tone_gen import fir_pkg::*; (
	input  logic                     clk_i,
	input  logic                     rst_ni,
	input  logic                     step_i,
	output logic signed [DATA_W-1:0] tone_o
);

	tone_phase_t              phase_q;
	logic [3:0]               rd_idx;
	logic signed [DATA_W-1:0] mag;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			phase_q <= '0;
		end else if (step_i) begin
			phase_q <= phase_q + 1'b1;
		end
	end

	// odd quarters run the table backwards
	assign rd_idx = phase_q.quarter[0] ? ~phase_q.idx : phase_q.idx;
	assign mag    = TONE_TABLE[rd_idx];

	// second half of the period is negative
	assign tone_o = phase_q.quarter[1] ? -mag : mag;

endmodule

`default_nettype wire

// ==== verilog/fir_parallel.sv ====
`timescale 1ns/10ps
`default_nettype none

module fir_parallel import fir_pkg::*; (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    valid_i,
	input  logic       [DATA_W-1:0] sample_i,
	output logic                    valid_o,
	output logic signed [SUM_W-1:0] y_o,
	input  apb_req_t                apb_i,
	output apb_rsp_t                apb_o
);

	apb_req_t                regs_req;
	apb_rsp_t                regs_rsp;
	apb_req_t                seg_req [NUM_SEG];
	apb_rsp_t                seg_rsp [NUM_SEG];
	logic                    tone_en;
	logic                    inject_valid;
	logic [DATA_W-1:0]       inject_data;
	logic                    valid_q;
	logic                    valid_edge;
	logic                    in_flight;
	logic                    accept_q;
	logic                    busy_q;
	logic                    overrun_q;
	logic [DATA_W-1:0]       sample_q;
	logic [DATA_W-1:0]       shift_out_q;
	logic [DATA_W-1:0]       seg_in [NUM_SEG];
	logic [DATA_W-1:0]       seg_shift [NUM_SEG];
	seg_part_t               parts;
	logic [NUM_SEG-1:0]      part_valid;
	logic                    tree_valid;
	logic signed [SUM_W-1:0] tree_sum;
	logic signed [DATA_W-1:0] tone;
	logic signed [SUM_W-1:0] tone_ext;
	fir_out_t                out_q;

	apb_splitter i_splitter (
		.clk_i,
		.rst_ni,
		.apb_i,
		.apb_o,
		.regs_req_o(regs_req),
		.regs_rsp_i(regs_rsp),
		.seg_req_o (seg_req),
		.seg_rsp_i (seg_rsp)
	);

	fir_regs i_regs (
		.clk_i,
		.rst_ni,
		.req_i         (regs_req),
		.rsp_o         (regs_rsp),
		.tone_en_o     (tone_en),
		.inject_valid_o(inject_valid),
		.inject_data_o (inject_data),
		.accept_i      (accept_q),
		.overrun_i     (overrun_q),
		.result_i      (out_q)
	);

	assign valid_edge = valid_i & ~valid_q;
	assign in_flight  = accept_q | busy_q;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q     <= 1'b0;
			accept_q    <= 1'b0;
			overrun_q   <= 1'b0;
			busy_q      <= 1'b0;
			sample_q    <= '0;
			shift_out_q <= '0;
		end else begin
			valid_q   <= valid_i;
			accept_q  <= valid_edge & ~in_flight;
			overrun_q <= valid_edge & in_flight;
			// injected sample takes the place of the port once
			if (valid_edge && !in_flight) begin
				sample_q <= inject_valid ? inject_data : sample_i;
			end
			if (accept_q) begin
				busy_q      <= 1'b1;
				shift_out_q <= seg_shift[NUM_SEG-1];
			end else if (tree_valid) begin
				busy_q <= 1'b0;
			end
		end
	end

	// segments chained oldest sample to newest tap
	for (genvar k = 0; k < NUM_SEG; k++) begin : g_seg
		if (k == 0) begin : g_head
			assign seg_in[k] = sample_q;
		end else begin : g_link
			assign seg_in[k] = seg_shift[k-1];
		end

		fir_segment i_seg (
			.clk_i,
			.rst_ni,
			.req_i       (seg_req[k]),
			.rsp_o       (seg_rsp[k]),
			.start_i     (accept_q),
			.sample_i    (seg_in[k]),
			.shift_o     (seg_shift[k]),
			.part_o      (parts[k]),
			.part_valid_o(part_valid[k])
		);
	end

	adder_tree i_tree (
		.clk_i,
		.rst_ni,
		.valid_i(&part_valid),
		.parts_i(parts),
		.valid_o(tree_valid),
		.sum_o  (tree_sum)
	);

	tone_gen i_tone (
		.clk_i,
		.rst_ni,
		.step_i(accept_q),
		.tone_o(tone)
	);

	assign tone_ext = tone;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			out_q <= '0;
		end else begin
			out_q.valid <= tree_valid;
			if (tree_valid) begin
				out_q.y         <= tone_en ? tone_ext : tree_sum;
				out_q.shift_out <= shift_out_q;
			end
		end
	end

	assign valid_o = out_q.valid;
	assign y_o     = out_q.y;

endmodule

`default_nettype wire

// ==== testbench/tb_fir_parallel.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fir_parallel import fir_pkg::*; ();

	localparam logic [31:0] SEED = 32'h0622_d30d;

	typedef enum {OP_WRITE, OP_READ, OP_SAMPLE, OP_PAIR, OP_BURST} op_e;
	typedef enum {EXP_TABLE, EXP_MODEL, EXP_ERR} kind_e;

	typedef struct {
		string             name;
		op_e               op;
		logic [ADDR_W-1:0] addr;
		logic [31:0]       data;
		logic [31:0]       exp;
		kind_e             kind;
	} step_t;

	logic                    clk;
	logic                    rst_n;
	logic                    valid;
	logic [DATA_W-1:0]       sample;
	logic                    out_valid;
	logic signed [SUM_W-1:0] y;
	apb_req_t                apb_req;
	apb_rsp_t                apb_rsp;

	step_t steps [$];
	logic  steps_ready = 1'b0;

	// reference model state
	longint            line_m [TOTAL_TAPS] = '{default: 0};
	longint            coef_m [TOTAL_TAPS] = '{default: 0};
	logic              tone_en_m = 1'b0;
	logic              pend_m = 1'b0;
	logic [DATA_W-1:0] inject_m = '0;
	int                phase_m = 0;
	int                overrun_m = 0;
	longint            last_y_m = 0;
	logic [DATA_W-1:0] last_shift_m = '0;

	fir_parallel i_dut (
		.clk_i   (clk),
		.rst_ni  (rst_n),
		.valid_i (valid),
		.sample_i(sample),
		.valid_o (out_valid),
		.y_o     (y),
		.apb_i   (apb_req),
		.apb_o   (apb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_sum(input string name, input logic signed [SUM_W-1:0] exp,
			input logic signed [SUM_W-1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("ERROR %s: expected y %0d, got %0d", name, exp, act));
		end
	endtask

	task automatic check_rsp(input string name, input apb_rsp_t exp, input apb_rsp_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERROR %s: expected prdata %h pready %b pslverr %b, got %h %b %b",
				name, exp.prdata, exp.pready, exp.pslverr, act.prdata, act.pready, act.pslverr));
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("ERROR %s: expected latency %0d, got %0d", name, exp, act));
		end
	endtask

	function automatic logic [ADDR_W-1:0] coef_addr(input int seg, input int idx);
		return {4'(seg + 1), 8'(idx)};
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input logic [7:0] off);
		return {TGT_REGS, off};
	endfunction

	// quarter wave, odd quarters mirrored, upper half negated
	function automatic longint tone_value(input int phase);
		int     q;
		int     i;
		longint v;
		q = phase / 16;
		i = phase % 16;
		if (q == 1 || q == 3) begin
			i = 15 - i;
		end
		v = longint'(TONE_TABLE[i]);
		if (q >= 2) begin
			v = -v;
		end
		return v;
	endfunction

	function automatic void model_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
		logic [3:0] tgt;
		logic [7:0] off;
		tgt = addr[11:8];
		off = addr[7:0];
		if (tgt == TGT_REGS && off == REG_CTRL) begin
			tone_en_m = data[0];
		end else if (tgt == TGT_REGS && off == REG_SAMPLE) begin
			pend_m   = 1'b1;
			inject_m = data[DATA_W-1:0];
		end else if (tgt != TGT_REGS && int'(tgt) <= NUM_SEG && int'(off) < TAPS_PER_SEG) begin
			coef_m[(int'(tgt) - 1) * TAPS_PER_SEG + int'(off)] = longint'($signed(data[COEF_W-1:0]));
		end
	endfunction

	function automatic logic [31:0] model_read(input logic [ADDR_W-1:0] addr);
		logic [3:0]  tgt;
		logic [7:0]  off;
		logic [31:0] rd;
		tgt = addr[11:8];
		off = addr[7:0];
		rd  = '0;
		if (tgt == TGT_REGS) begin
			case (off)
				REG_CTRL:      rd = {31'b0, tone_en_m};
				REG_Y_LO:      rd = last_y_m[31:0];
				REG_Y_HI:      rd = last_y_m[63:32];
				REG_SHIFT_OUT: rd = {{(32 - DATA_W){last_shift_m[DATA_W-1]}}, last_shift_m};
				REG_OVERRUN:   rd = 32'(overrun_m);
				default:       rd = '0;
			endcase
		end else begin
			rd = coef_m[(int'(tgt) - 1) * TAPS_PER_SEG + int'(off)][31:0];
		end
		return rd;
	endfunction

	// one accepted sample through the full tap line
	task automatic model_accept(input logic [DATA_W-1:0] port, output longint y_exp);
		logic [DATA_W-1:0] s;
		longint            sum;
		s      = pend_m ? inject_m : port;
		pend_m = 1'b0;
		last_shift_m = line_m[TOTAL_TAPS-1][DATA_W-1:0];
		for (int g = TOTAL_TAPS - 1; g > 0; g--) begin
			line_m[g] = line_m[g-1];
		end
		line_m[0] = longint'($signed(s));
		phase_m   = (phase_m + 1) % 64;
		sum = 0;
		for (int g = 0; g < TOTAL_TAPS; g++) begin
			sum += line_m[g] * coef_m[g];
		end
		y_exp    = tone_en_m ? tone_value(phase_m) : sum;
		last_y_m = y_exp;
	endtask

	task automatic apb_xfer(input logic write, input logic [ADDR_W-1:0] addr,
			input logic [31:0] wdata, output apb_rsp_t rsp);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		// response is combinational in the access phase
		@(negedge clk);
		rsp = apb_rsp;
		@(posedge clk);
		#1;
		apb_req = '0;
	endtask

	task automatic apply_sample(input string name, input logic [DATA_W-1:0] smp,
			input logic pair, input logic from_table, input logic [31:0] exp_tab);
		longint exp_y;
		int     lat;
		int     extra;
		valid  = 1'b1;
		sample = smp;
		model_accept(smp, exp_y);
		if (from_table) begin
			exp_y = longint'($signed(exp_tab));
		end
		@(posedge clk);
		#1;
		valid = 1'b0;
		lat   = 0;
		if (pair) begin
			// second edge while the first sample is in flight
			@(posedge clk);
			#1;
			valid  = 1'b1;
			sample = ~smp;
			@(posedge clk);
			#1;
			valid = 1'b0;
			lat   = 2;
			if (overrun_m < 16'hffff) begin
				overrun_m++;
			end
		end
		while (!out_valid && lat <= 2 * FIR_LATENCY) begin
			@(posedge clk);
			#1;
			lat++;
		end
		if (!out_valid) begin
			abort_run($sformatf("%s: valid_o never came after the valid_i edge", name));
		end else begin
			check_latency(name, FIR_LATENCY, lat);
			check_sum(name, SUM_W'(exp_y), y);
			extra = 0;
			repeat (pair ? FIR_LATENCY + 2 : 1) begin
				@(posedge clk);
				#1;
				if (out_valid) begin
					extra++;
				end
			end
			if (extra != 0) begin
				abort_run($sformatf("%s: valid_o stayed high or pulsed a second time", name));
			end
		end
	endtask

	task automatic run_step(input step_t s);
		apb_rsp_t want;
		apb_rsp_t got;
		want = '{prdata: '0, pready: 1'b1, pslverr: s.kind == EXP_ERR};
		case (s.op)
			OP_WRITE, OP_READ: begin
				if (s.op == OP_READ && s.kind == EXP_TABLE) begin
					want.prdata = s.exp;
				end else if (s.op == OP_READ && s.kind == EXP_MODEL) begin
					want.prdata = model_read(s.addr);
				end
				apb_xfer(s.op == OP_WRITE, s.addr, s.data, got);
				if (s.op == OP_WRITE && s.kind != EXP_ERR) begin
					model_write(s.addr, s.data);
				end
				check_rsp(s.name, want, got);
			end
			OP_SAMPLE: apply_sample(s.name, s.data[DATA_W-1:0], 1'b0, s.kind == EXP_TABLE, s.exp);
			OP_PAIR:   apply_sample(s.name, s.data[DATA_W-1:0], 1'b1, 1'b0, '0);
			OP_BURST: begin
				for (int n = 0; n < int'(s.data); n++) begin
					apply_sample($sformatf("%s_%0d", s.name, n), DATA_W'($urandom), 1'b0, 1'b0, '0);
				end
			end
			default: abort_run($sformatf("%s: unknown operation in the stimulus table", s.name));
		endcase
	endtask

	task automatic add_step(input string name, input op_e op, input logic [ADDR_W-1:0] addr,
			input logic [31:0] data, input logic [31:0] exp, input kind_e kind);
		step_t s;
		s = '{name: name, op: op, addr: addr, data: data, exp: exp, kind: kind};
		steps.push_back(s);
	endtask

	task automatic build_steps();
		// segment 0 holds taps 0 to 3, segment 1 taps 4 to 7
		add_step("coef_w0_0", OP_WRITE, coef_addr(0, 0), 32'd3, '0, EXP_TABLE);
		add_step("coef_w0_1", OP_WRITE, coef_addr(0, 1), 32'hfffb, '0, EXP_TABLE);
		add_step("coef_w0_2", OP_WRITE, coef_addr(0, 2), 32'd7, '0, EXP_TABLE);
		add_step("coef_w0_3", OP_WRITE, coef_addr(0, 3), 32'd100, '0, EXP_TABLE);
		add_step("coef_w1_0", OP_WRITE, coef_addr(1, 0), 32'hfffe, '0, EXP_TABLE);
		add_step("coef_w1_1", OP_WRITE, coef_addr(1, 1), 32'd11, '0, EXP_TABLE);
		add_step("coef_w1_2", OP_WRITE, coef_addr(1, 2), 32'd1000, '0, EXP_TABLE);
		add_step("coef_w1_3", OP_WRITE, coef_addr(1, 3), 32'hfed4, '0, EXP_TABLE);
		add_step("coef_r0_1", OP_READ, coef_addr(0, 1), '0, 32'hffff_fffb, EXP_TABLE);
		add_step("coef_r0_3", OP_READ, coef_addr(0, 3), '0, 32'd100, EXP_TABLE);
		add_step("coef_r1_2", OP_READ, coef_addr(1, 2), '0, 32'd1000, EXP_TABLE);
		add_step("coef_r1_3", OP_READ, coef_addr(1, 3), '0, 32'hffff_fed4, EXP_TABLE);
		add_step("bad_target_rd", OP_READ, 12'h300, '0, '0, EXP_ERR);
		add_step("bad_target_wr", OP_WRITE, 12'hf00, 32'h55, '0, EXP_ERR);
		add_step("bad_index_rd", OP_READ, coef_addr(0, 4), '0, '0, EXP_ERR);
		add_step("bad_index_wr", OP_WRITE, coef_addr(1, 4), 32'h1111, '0, EXP_ERR);
		add_step("no_alias_rd", OP_READ, coef_addr(1, 0), '0, 32'hffff_fffe, EXP_TABLE);
		add_step("bad_offset_rd", OP_READ, reg_addr(8'h20), '0, '0, EXP_ERR);
		// impulse walks the coefficients out in tap order
		add_step("impulse_0", OP_SAMPLE, '0, 32'd1, 32'd3, EXP_TABLE);
		add_step("impulse_1", OP_SAMPLE, '0, 32'd0, 32'hffff_fffb, EXP_TABLE);
		add_step("impulse_2", OP_SAMPLE, '0, 32'd0, 32'd7, EXP_TABLE);
		add_step("impulse_3", OP_SAMPLE, '0, 32'd0, 32'd100, EXP_TABLE);
		add_step("impulse_4", OP_SAMPLE, '0, 32'd0, 32'hffff_fffe, EXP_TABLE);
		add_step("impulse_5", OP_SAMPLE, '0, 32'd0, 32'd11, EXP_TABLE);
		add_step("impulse_6", OP_SAMPLE, '0, 32'd0, 32'd1000, EXP_TABLE);
		add_step("impulse_7", OP_SAMPLE, '0, 32'd0, 32'hffff_fed4, EXP_TABLE);
		add_step("y_lo_rd", OP_READ, reg_addr(REG_Y_LO), '0, 32'hffff_fed4, EXP_TABLE);
		add_step("y_hi_rd", OP_READ, reg_addr(REG_Y_HI), '0, 32'hffff_ffff, EXP_TABLE);
		// full scale coefficients widen the sum
		add_step("coef_big_0", OP_WRITE, coef_addr(0, 0), 32'h7fff, '0, EXP_TABLE);
		add_step("coef_big_7", OP_WRITE, coef_addr(1, 3), 32'h8000, '0, EXP_TABLE);
		add_step("random", OP_BURST, '0, 32'd12, '0, EXP_MODEL);
		add_step("y_hi_model", OP_READ, reg_addr(REG_Y_HI), '0, '0, EXP_MODEL);
		add_step("inject_wr", OP_WRITE, reg_addr(REG_SAMPLE), 32'h1234, '0, EXP_TABLE);
		add_step("sample_rd", OP_READ, reg_addr(REG_SAMPLE), '0, '0, EXP_TABLE);
		add_step("injected", OP_SAMPLE, '0, 32'h5555, '0, EXP_MODEL);
		add_step("port_after", OP_SAMPLE, '0, 32'h0777, '0, EXP_MODEL);
		add_step("shift_out_rd", OP_READ, reg_addr(REG_SHIFT_OUT), '0, '0, EXP_MODEL);
		add_step("pair_a", OP_PAIR, '0, 32'h0100, '0, EXP_MODEL);
		add_step("overrun_1", OP_READ, reg_addr(REG_OVERRUN), '0, '0, EXP_MODEL);
		add_step("pair_b", OP_PAIR, '0, 32'hff00, '0, EXP_MODEL);
		add_step("overrun_2", OP_READ, reg_addr(REG_OVERRUN), '0, 32'd2, EXP_TABLE);
		// tone replaces the sum, long enough to pass every quarter
		add_step("tone_on", OP_WRITE, reg_addr(REG_CTRL), 32'd1, '0, EXP_TABLE);
		add_step("ctrl_rd", OP_READ, reg_addr(REG_CTRL), '0, 32'd1, EXP_TABLE);
		add_step("tone", OP_BURST, '0, 32'd44, '0, EXP_MODEL);
		add_step("tone_off", OP_WRITE, reg_addr(REG_CTRL), 32'd0, '0, EXP_TABLE);
		add_step("filter_again", OP_BURST, '0, 32'd2, '0, EXP_MODEL);
		add_step("y_lo_model", OP_READ, reg_addr(REG_Y_LO), '0, '0, EXP_MODEL);
	endtask

	initial begin : watchdog
		int budget;
		wait (steps_ready);
		budget = 0;
		foreach (steps[i]) begin
			budget += (steps[i].op == OP_BURST) ? int'(steps[i].data) : 1;
		end
		budget = budget * (FIR_LATENCY + 10) + 8;
		repeat (budget) @(posedge clk);
		abort_run($sformatf("timeout, the run did not finish within %0d cycles", budget));
	end

	initial begin : main
		void'($urandom(SEED));
		rst_n   = 1'b0;
		valid   = 1'b0;
		sample  = '0;
		apb_req = '0;
		build_steps();
		steps_ready = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/fir_pkg.sv
verilog/apb_splitter.sv
verilog/fir_regs.sv
verilog/fir_segment.sv
verilog/adder_tree.sv
verilog/tone_gen.sv
verilog/fir_parallel.sv
testbench/tb_fir_parallel.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_fir_parallel -o sim_fir_parallel &&
./obj_dir/sim_fir_parallel ||
{ echo "simulation failed"; exit 1; }
